// File: design/dot_pkg.sv
// dot-product engine shared definitions
`default_nettype none

package dot_pkg;

  // ********************************************************************
  // data widths
  // ********************************************************************
  // one signed weight, one signed activation
  localparam int wgt_width      = 16;
  localparam int act_width      = 16;
  // four weights per host word, lowest lane first
  localparam int lanes          = 4;
  localparam int lane_sel_width = 2;
  localparam int wr_width       = lanes * wgt_width;
  // accumulator and result, wraps at this width
  localparam int acc_width      = 40;

  // ********************************************************************
  // address space
  // ********************************************************************
  localparam int wr_addr_width  = 5;
  localparam int idx_width      = 7;
  localparam int wgt_depth      = 1 << wr_addr_width;
  localparam int act_depth      = 1 << idx_width;

  // read strobe to read data, both buffers
  localparam int rd_latency     = 3;

  // job controller states
  typedef enum logic [1:0] {st_idle, st_issue, st_drain} ctrl_state_e;

endpackage

`default_nettype wire

// File: design/mac_if.sv
// controller to multiply-accumulate link
`timescale 1ns/1ps
`default_nettype none

interface mac_if import dot_pkg::*; ();
  // accumulate strobe; first/last qualify it
  logic                        acc_valid;
  logic                        acc_first;
  logic                        acc_last;
  // final sum, one-cycle strobe
  logic signed [acc_width-1:0] result;
  logic                        result_valid;

  modport ctrl (output acc_valid, acc_first, acc_last, input result_valid);
  modport mac  (input acc_valid, acc_first, acc_last, output result, result_valid);

endinterface

`default_nettype wire

// File: design/weight_buffer.sv
// packed weight store
`timescale 1ns/1ps
`default_nettype none

module weight_buffer import dot_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        read_req,
  input  logic [idx_width-1:0]        read_idx,
  input  logic                        write_req,
  input  logic [wr_addr_width-1:0]    write_addr,
  input  logic [wr_width-1:0]         write_data,
  output logic signed [wgt_width-1:0] read_data
);

  // ********************************************************************
  // storage and pipeline registers
  // ********************************************************************
  logic [wr_width-1:0]                mem [wgt_depth];
  // stage one
  logic [wr_addr_width-1:0]           word_addr;
  logic [lane_sel_width-1:0]          lane_sel;
  logic                               read_req_d;
  // stage two
  logic [lanes-1:0][wgt_width-1:0]    mem_q;
  logic [lane_sel_width-1:0]          lane_sel_d;

  // ********************************************************************
  // host write, one whole word per cycle
  // ********************************************************************
  always_ff @(posedge clk)
  begin
    if (write_req)
      mem[write_addr] <= write_data;
  end

  // ********************************************************************
  // read pipeline
  // ********************************************************************
  // stage one: split index into word and lane
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      word_addr  <= '0;
      lane_sel   <= '0;
      read_req_d <= 1'b0;
    end
    else
    begin
      read_req_d <= read_req;
      if (read_req)
        {word_addr, lane_sel} <= read_idx;
    end
  end

  // stage two: fetch the packed word
  always_ff @(posedge clk)
  begin
    if (read_req_d)
      mem_q <= mem[word_addr];
    // lane select follows the word by one stage
    lane_sel_d <= lane_sel;
  end

  // stage three: pick the lane, lane 0 in the low bits
  always_ff @(posedge clk)
  begin
    read_data <= mem_q[lane_sel_d];
  end

endmodule

`default_nettype wire

// File: design/act_buffer.sv
// activation store
`timescale 1ns/1ps
`default_nettype none

module act_buffer import dot_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        read_req,
  input  logic [idx_width-1:0]        read_idx,
  input  logic                        write_req,
  input  logic [idx_width-1:0]        write_addr,
  input  logic [act_width-1:0]        write_data,
  output logic signed [act_width-1:0] read_data
);

  logic [act_width-1:0] mem [act_depth];
  logic [idx_width-1:0] idx_q;
  logic                 read_req_d;
  logic [act_width-1:0] mem_q;

  // host write, one element per cycle
  always_ff @(posedge clk)
  begin
    if (write_req)
      mem[write_addr] <= write_data;
  end

  // stage one: hold index, delay strobe
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      idx_q      <= '0;
      read_req_d <= 1'b0;
    end
    else
    begin
      read_req_d <= read_req;
      if (read_req)
        idx_q <= read_idx;
    end
  end

  // stage two: memory read; stage three: output register
  // matches the weight store cycle for cycle
  always_ff @(posedge clk)
  begin
    if (read_req_d)
      mem_q <= mem[idx_q];
    read_data <= mem_q;
  end

endmodule

`default_nettype wire

// File: design/dot_ctrl.sv
// dot-product job controller
`timescale 1ns/1ps
`default_nettype none

module dot_ctrl import dot_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 start,
  input  logic [idx_width-1:0] base_idx,
  input  logic [idx_width-1:0] len_m1,
  output logic                 busy,
  output logic                 read_req,
  output logic [idx_width-1:0] read_idx,
  mac_if.ctrl                  mac
);

  // ********************************************************************
  // job state
  // ********************************************************************
  ctrl_state_e          state;
  // remaining reads after the current one
  logic [idx_width-1:0] count;
  // marks the first read of a job
  logic                 first_q;
  logic                 accept;
  // strobe and marks, delayed to meet the buffer data
  logic [rd_latency-1:0] valid_sr;
  logic [rd_latency-1:0] first_sr;
  logic [rd_latency-1:0] last_sr;

  // busy drops with the result strobe
  assign busy   = (state != st_idle) && !mac.result_valid;
  // start only taken when not busy
  assign accept = start && !busy;

  // ********************************************************************
  // FSM and read address walk
  // ********************************************************************
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state    <= st_idle;
      read_req <= 1'b0;
      read_idx <= '0;
      count    <= '0;
      first_q  <= 1'b0;
    end
    else if (accept)
    begin
      // latch job, first read goes out next cycle
      state    <= st_issue;
      read_req <= 1'b1;
      read_idx <= base_idx;
      count    <= len_m1;
      first_q  <= 1'b1;
    end
    else
    begin
      case (state)
        st_issue:
        begin
          first_q <= 1'b0;
          if (count == '0)
          begin
            read_req <= 1'b0;
            state    <= st_drain;
          end
          else
          begin
            // index wraps modulo 128
            read_idx <= read_idx + 1'b1;
            count    <= count - 1'b1;
          end
        end
        st_drain:
        begin
          // wait for the sum to come back
          if (mac.result_valid)
            state <= st_idle;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  // ********************************************************************
  // delay line, rd_latency deep
  // ********************************************************************
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid_sr <= '0;
      first_sr <= '0;
      last_sr  <= '0;
    end
    else
    begin
      valid_sr <= {valid_sr[rd_latency-2:0], read_req};
      first_sr <= {first_sr[rd_latency-2:0], read_req && first_q};
      // last read is the one with nothing left to count
      last_sr  <= {last_sr[rd_latency-2:0], read_req && (count == '0)};
    end
  end

  assign mac.acc_valid = valid_sr[rd_latency-1];
  assign mac.acc_first = first_sr[rd_latency-1];
  assign mac.acc_last  = last_sr[rd_latency-1];

endmodule

`default_nettype wire

// File: design/mac_unit.sv
// signed multiply-accumulate
`timescale 1ns/1ps
`default_nettype none

module mac_unit import dot_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic signed [wgt_width-1:0] weight,
  input  logic signed [act_width-1:0] act,
  mac_if.mac                          mac
);

  logic signed [acc_width-1:0] prod;
  logic signed [acc_width-1:0] sum;
  logic signed [acc_width-1:0] acc;

  // operands sign-extended before the multiply
  assign prod = acc_width'(weight) * acc_width'(act);

  // first product restarts the sum, no carry-over between jobs
  assign sum = mac.acc_first ? prod : acc + prod;

  // ********************************************************************
  // accumulator
  // ********************************************************************
  always_ff @(posedge clk)
  begin
    if (mac.acc_valid)
      acc <= sum;
  end

  // ********************************************************************
  // result register
  // ********************************************************************
  // last term goes straight into result, strobe for one cycle
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      mac.result       <= '0;
      mac.result_valid <= 1'b0;
    end
    else
    begin
      mac.result_valid <= mac.acc_valid && mac.acc_last;
      if (mac.acc_valid && mac.acc_last)
        mac.result <= sum;
    end
  end

endmodule

`default_nettype wire

// File: design/dot_engine_top.sv
// dot-product engine top level
`timescale 1ns/1ps
`default_nettype none

module dot_engine_top import dot_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  // host weight port, four lanes per word
  input  logic                        wgt_wr_en,
  input  logic [wr_addr_width-1:0]    wgt_wr_addr,
  input  logic [wr_width-1:0]         wgt_wr_data,
  // host activation port
  input  logic                        act_wr_en,
  input  logic [idx_width-1:0]        act_wr_addr,
  input  logic [act_width-1:0]        act_wr_data,
  // job control
  input  logic                        start,
  input  logic [idx_width-1:0]        base_idx,
  input  logic [idx_width-1:0]        len_m1,
  output logic                        busy,
  output logic                        result_valid,
  output logic signed [acc_width-1:0] result
);

  // shared read strobe and index
  logic                        read_req;
  logic [idx_width-1:0]        read_idx;
  // buffer data into the MAC
  logic signed [wgt_width-1:0] weight;
  logic signed [act_width-1:0] act;

  mac_if mac_bus ();

  weight_buffer i_wgt_buf (
    .clk        (clk),
    .reset      (reset),
    .read_req   (read_req),
    .read_idx   (read_idx),
    .write_req  (wgt_wr_en),
    .write_addr (wgt_wr_addr),
    .write_data (wgt_wr_data),
    .read_data  (weight)
  );

  act_buffer i_act_buf (
    .clk        (clk),
    .reset      (reset),
    .read_req   (read_req),
    .read_idx   (read_idx),
    .write_req  (act_wr_en),
    .write_addr (act_wr_addr),
    .write_data (act_wr_data),
    .read_data  (act)
  );

  dot_ctrl i_ctrl (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .base_idx (base_idx),
    .len_m1   (len_m1),
    .busy     (busy),
    .read_req (read_req),
    .read_idx (read_idx),
    .mac      (mac_bus.ctrl)
  );

  mac_unit i_mac (
    .clk    (clk),
    .reset  (reset),
    .weight (weight),
    .act    (act),
    .mac    (mac_bus.mac)
  );

  // result leaves as plain ports
  assign result       = mac_bus.result;
  assign result_valid = mac_bus.result_valid;

endmodule

`default_nettype wire

// File: verif/dot_ctrl_sva.sv
// controller protocol assertions
`timescale 1ns/1ps
`default_nettype none

module dot_ctrl_sva import dot_pkg::*;
(
  input logic                 clk,
  input logic                 reset,
  input logic                 start,
  input logic                 busy,
  input logic                 read_req,
  input logic                 result_valid,
  input ctrl_state_e          state,
  input logic [idx_width-1:0] count
);

  // count the walk would reach without any new start
  logic [idx_width-1:0] walk_count;

  assign walk_count = (state == st_issue && count != '0) ? count - 1'b1 : count;

  // reads only while a job runs
  read_in_job: assert property (@(posedge clk) disable iff (reset) read_req |-> busy)
    else $error("read_req high outside a job");

  // single-cycle result strobe
  strobe_single: assert property (@(posedge clk) disable iff (reset)
    result_valid |=> !result_valid)
    else $error("result_valid held for two cycles");

  // start during a job must not reload the count
  start_ignored: assert property (@(posedge clk) disable iff (reset)
    (start && busy) |=> (count == $past(walk_count)))
    else $error("start while busy changed the job count");

endmodule

bind dot_ctrl dot_ctrl_sva i_ctrl_sva (
  .clk          (clk),
  .reset        (reset),
  .start        (start),
  .busy         (busy),
  .read_req     (read_req),
  .result_valid (mac.result_valid),
  .state        (state),
  .count        (count)
);

`default_nettype wire

// File: verif/tb_dot_engine.sv
// dot-product engine testbench
`timescale 1ns/1ps
`default_nettype none

module tb_dot_engine import dot_pkg::*; ();

  logic                        clk;
  logic                        reset;
  logic                        wgt_wr_en;
  logic [wr_addr_width-1:0]    wgt_wr_addr;
  logic [wr_width-1:0]         wgt_wr_data;
  logic                        act_wr_en;
  logic [idx_width-1:0]        act_wr_addr;
  logic [act_width-1:0]        act_wr_data;
  logic                        start;
  logic [idx_width-1:0]        base_idx;
  logic [idx_width-1:0]        len_m1;
  logic                        busy;
  logic                        result_valid;
  logic signed [acc_width-1:0] result;

  // shadow memories, one entry per element index
  logic signed [wgt_width-1:0] wgt_model [act_depth];
  logic signed [act_width-1:0] act_model [act_depth];
  int                          errors;
  int                          checks;

  dot_engine_top i_dut (
    .clk          (clk),
    .reset        (reset),
    .wgt_wr_en    (wgt_wr_en),
    .wgt_wr_addr  (wgt_wr_addr),
    .wgt_wr_data  (wgt_wr_data),
    .act_wr_en    (act_wr_en),
    .act_wr_addr  (act_wr_addr),
    .act_wr_data  (act_wr_data),
    .start        (start),
    .base_idx     (base_idx),
    .len_m1       (len_m1),
    .busy         (busy),
    .result_valid (result_valid),
    .result       (result)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ********************************************************************
  // checks and reference model
  // ********************************************************************
  task automatic check_value(input string name, input logic [acc_width-1:0] got,
                             input logic [acc_width-1:0] exp);
    checks++;
    assert (got == exp)
    else
    begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    assert (got == exp)
    else
    begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // element i lives in word i/4, lane i mod 4; indices wrap at 128
  function automatic logic signed [acc_width-1:0] expected_dot(input int base, input int count);
    longint sum;
    int     idx;
    sum = 0;
    for (int k = 0; k < count; k++)
    begin
      idx = (base + k) % act_depth;
      sum += longint'(wgt_model[idx]) * longint'(act_model[idx]);
    end
    // 40-bit wrap
    return acc_width'(sum);
  endfunction

  // ********************************************************************
  // host loads
  // ********************************************************************
  task automatic randomize_models();
    for (int i = 0; i < act_depth; i++)
    begin
      wgt_model[i] = wgt_width'($urandom);
      act_model[i] = act_width'($urandom);
    end
  endtask

  // pack four weights per word, lowest lane in the low bits
  task automatic load_weights();
    logic [wr_width-1:0] word;
    for (int w = 0; w < wgt_depth; w++)
    begin
      for (int l = 0; l < lanes; l++)
        word[l*wgt_width +: wgt_width] = wgt_model[w*lanes + l];
      @(posedge clk);
      wgt_wr_en   <= 1'b1;
      wgt_wr_addr <= wr_addr_width'(w);
      wgt_wr_data <= word;
    end
    @(posedge clk);
    wgt_wr_en <= 1'b0;
  endtask

  task automatic load_acts();
    for (int i = 0; i < act_depth; i++)
    begin
      @(posedge clk);
      act_wr_en   <= 1'b1;
      act_wr_addr <= idx_width'(i);
      act_wr_data <= act_model[i];
    end
    @(posedge clk);
    act_wr_en <= 1'b0;
  endtask

  // ********************************************************************
  // job control
  // ********************************************************************
  // returns just after the edge that samples start
  task automatic launch_job(input int base, input int count);
    @(posedge clk);
    start    <= 1'b1;
    base_idx <= idx_width'(base);
    len_m1   <= idx_width'(count - 1);
    @(posedge clk);
    start    <= 1'b0;
  endtask

  // cycle 1 follows the sampling edge; strobe due in cycle n+4
  task automatic await_result(input int count, input int elapsed,
                              output logic signed [acc_width-1:0] res);
    int lat;
    bit got;
    lat = elapsed + 1;
    got = 1'b0;
    res = '0;
    while (!got && lat <= count + 24)
    begin
      @(negedge clk);
      if (lat == 1)
        check_flag("busy", busy, 1'b1);
      if (result_valid)
      begin
        got = 1'b1;
        res = result;
      end
      else
        lat++;
    end
    checks++;
    assert (got)
    else
    begin
      $display("timeout: result_valid did not arrive within %0d cycles of start", lat - 1);
      errors++;
    end
    if (got)
    begin
      checks++;
      assert (lat == count + 4)
      else
      begin
        $display("result_valid came %0d cycles after start instead of %0d", lat, count + 4);
        errors++;
      end
      // busy drops together with the strobe
      check_flag("busy", busy, 1'b0);
    end
  endtask

  task automatic run_and_check(input int base, input int count);
    logic signed [acc_width-1:0] res;
    launch_job(base, count);
    await_result(count, 0, res);
    check_value("result", res, expected_dot(base, count));
  endtask

  // ********************************************************************
  // directed tests
  // ********************************************************************
  task automatic reset_state_test();
    @(negedge clk);
    check_flag("busy", busy, 1'b0);
    check_flag("result_valid", result_valid, 1'b0);
    check_value("result", result, '0);
  endtask

  // one-element jobs over two words, signed corners included
  task automatic lane_mapping_test();
    logic signed [15:0] w_vals [8] = '{16'sd3, -16'sd5, 16'sd7, -16'sd32768,
                                       16'sd32767, -16'sd1, 16'sd256, -16'sd300};
    logic signed [15:0] a_vals [8] = '{16'sd2, 16'sd11, -16'sd13, 16'sd9,
                                       -16'sd32768, 16'sd4, -16'sd1, 16'sd17};
    randomize_models();
    for (int i = 0; i < 8; i++)
    begin
      wgt_model[i] = w_vals[i];
      act_model[i] = a_vals[i];
    end
    load_weights();
    load_acts();
    for (int i = 0; i < 8; i++)
      run_and_check(i, 1);
  endtask

  task automatic full_length_test();
    randomize_models();
    load_weights();
    load_acts();
    run_and_check(0, act_depth);
  endtask

  // indices 120..127 then 0..11
  task automatic wrap_around_test();
    run_and_check(120, 20);
  endtask

  task automatic start_while_busy_test();
    logic signed [acc_width-1:0] res;
    int                          stray;
    launch_job(10, 30);
    // competing start mid-job
    @(posedge clk);
    start    <= 1'b1;
    base_idx <= 7'd90;
    len_m1   <= 7'd4;
    @(posedge clk);
    start    <= 1'b0;
    await_result(30, 2, res);
    check_value("result", res, expected_dot(10, 30));
    // nothing may follow the single strobe
    stray = 0;
    repeat (20)
    begin
      @(negedge clk);
      if (result_valid || busy)
        stray++;
    end
    checks++;
    assert (stray == 0)
    else
    begin
      $display("ignored start still produced activity for %0d cycles", stray);
      errors++;
    end
  endtask

  // second start lands in the cycle after the first strobe
  task automatic back_to_back_test();
    run_and_check(3, 9);
    run_and_check(64, 2);
  endtask

  // ********************************************************************
  // main sequence
  // ********************************************************************
  initial
  begin
    errors = 0;
    checks = 0;
    void'($urandom(32'hac62_fb03));
    reset       = 1'b1;
    wgt_wr_en   = 1'b0;
    wgt_wr_addr = '0;
    wgt_wr_data = '0;
    act_wr_en   = 1'b0;
    act_wr_addr = '0;
    act_wr_data = '0;
    start       = 1'b0;
    base_idx    = '0;
    len_m1      = '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    reset_state_test();
    lane_mapping_test();
    full_length_test();
    wrap_around_test();
    start_while_busy_test();
    back_to_back_test();
    repeat (4) @(posedge clk);
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
design/dot_pkg.sv
design/mac_if.sv
design/weight_buffer.sv
design/act_buffer.sv
design/dot_ctrl.sv
design/mac_unit.sv
design/dot_engine_top.sv
verif/dot_ctrl_sva.sv
verif/tb_dot_engine.sv

// File: run.sh
#!/bin/sh
# build and run the dot-product engine testbench with Verilator
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_dot_engine -f tb.f || { echo "build failed"; exit 1; }
./obj_dir/Vtb_dot_engine > sim.log 2>&1 || { cat sim.log; echo "simulation stopped"; exit 1; }
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "failure found in sim.log"; exit 1; } || exit 0
